/* files.f */
hdl/codebook_pkg.sv
hdl/ap_decode.sv
hdl/code_lookup.sv
hdl/codebook_encoder.sv
test/codebook_encoder_tb.sv

/* hdl/ap_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ap_decode (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire                    valid_i,
    input  wire codebook_pkg::ap_cnt_t  ap_cnt_i,
    input  wire codebook_pkg::ap_data_t ap_data_i,

    output logic                   valid_o,
    output codebook_pkg::ap_cnt_t  cnt_o,
    output codebook_pkg::ap_key_t  key_o,
    output logic                   in_range_o
);

    codebook_pkg::ap_data_t low_mask;   // ones over the counted digits
    logic                   cnt_ok;
    logic                   upper_zero;

    // count * 4 bits of ones, zero for count 0
    assign low_mask = (codebook_pkg::ap_data_t'(1) << (ap_cnt_i * codebook_pkg::SYM_W))
                      - codebook_pkg::ap_data_t'(1);

    assign cnt_ok = (ap_cnt_i != '0) &&
                    (ap_cnt_i <= codebook_pkg::ap_cnt_t'(codebook_pkg::KEPT_CNT_MAX));

    // stray digits above the count
    assign upper_zero = ~|(ap_data_i & ~low_mask);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            cnt_o      <= ap_cnt_i;
            key_o      <= ap_data_i[codebook_pkg::KEY_W-1:0];   // upper digits already checked
            in_range_o <= cnt_ok & upper_zero;
        end
    end

endmodule

`default_nettype wire

/* hdl/code_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module code_lookup (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        valid_i,
    input  wire codebook_pkg::ap_cnt_t cnt_i,
    input  wire codebook_pkg::ap_key_t key_i,
    input  wire                        in_range_i,

    output logic                       valid_o,
    output logic                       match_o,
    output codebook_pkg::code_len_t    length_o,
    output codebook_pkg::code_t        code_o
);

    logic                    tbl_hit;
    codebook_pkg::code_len_t tbl_len;
    codebook_pkg::code_t     tbl_code;
    logic                    hit;

    // digits in the keys: 0 SYM_ZERO, 1 SYM_ONE, 2 SYM_TWO, F SYM_ESC
    always_comb begin
        tbl_hit  = 1'b1;
        tbl_len  = '0;
        tbl_code = '0;
        case (cnt_i)
            6'd1: begin
                case (key_i)
                    24'h000001: {tbl_len, tbl_code} = {6'd4, 21'b0100};
                    24'h000002: {tbl_len, tbl_code} = {6'd4, 21'b0101};
                    24'h00000F: {tbl_len, tbl_code} = {6'd10, 21'b1111101000};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            6'd2: begin
                case (key_i)
                    24'h000001: {tbl_len, tbl_code} = {6'd4, 21'b0110};
                    24'h00000F: {tbl_len, tbl_code} = {6'd11, 21'b11111111000};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            6'd3: begin
                case (key_i)
                    24'h000021: {tbl_len, tbl_code} = {6'd8, 21'b11101000};
                    24'h000022: {tbl_len, tbl_code} = {6'd9, 21'b111011110};
                    24'h00000F: {tbl_len, tbl_code} = {6'd11, 21'b11111111001};
                    24'h00002F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110000};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            6'd4: begin
                case (key_i)
                    24'h000011: {tbl_len, tbl_code} = {6'd8, 21'b11101001};
                    24'h000012: {tbl_len, tbl_code} = {6'd8, 21'b11101010};
                    24'h000021: {tbl_len, tbl_code} = {6'd8, 21'b11101011};
                    24'h000201: {tbl_len, tbl_code} = {6'd8, 21'b11101100};
                    24'h000022: {tbl_len, tbl_code} = {6'd9, 21'b111011111};
                    24'h000202: {tbl_len, tbl_code} = {6'd9, 21'b111100000};
                    24'h00000F: {tbl_len, tbl_code} = {6'd11, 21'b11111111010};
                    24'h00001F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110001};
                    24'h00002F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110010};
                    24'h00020F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110011};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            6'd5: begin
                case (key_i)
                    24'h000200: {tbl_len, tbl_code} = {6'd5, 21'b10000};
                    24'h002000: {tbl_len, tbl_code} = {6'd5, 21'b10001};
                    24'h000002: {tbl_len, tbl_code} = {6'd5, 21'b01110};
                    24'h000020: {tbl_len, tbl_code} = {6'd5, 21'b01111};
                    24'h000101: {tbl_len, tbl_code} = {6'd8, 21'b11101110};
                    24'h000011: {tbl_len, tbl_code} = {6'd8, 21'b11101101};
                    24'h000102: {tbl_len, tbl_code} = {6'd9, 21'b111100100};
                    24'h000201: {tbl_len, tbl_code} = {6'd9, 21'b111100101};
                    24'h000202: {tbl_len, tbl_code} = {6'd9, 21'b111100110};
                    24'h002001: {tbl_len, tbl_code} = {6'd9, 21'b111100111};
                    24'h002002: {tbl_len, tbl_code} = {6'd9, 21'b111101000};
                    24'h000012: {tbl_len, tbl_code} = {6'd9, 21'b111100001};
                    24'h000021: {tbl_len, tbl_code} = {6'd9, 21'b111100010};
                    24'h000022: {tbl_len, tbl_code} = {6'd9, 21'b111100011};
                    24'h00000F: {tbl_len, tbl_code} = {6'd11, 21'b11111111011};
                    24'h00010F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110101};
                    24'h00200F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110110};
                    24'h00001F: {tbl_len, tbl_code} = {6'd15, 21'b111111111110100};
                    24'h00002F: {tbl_len, tbl_code} = {6'd16, 21'b1111111111110100};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            6'd6: begin
                case (key_i)
                    24'h001000: {tbl_len, tbl_code} = {6'd5, 21'b10110};
                    24'h000001: {tbl_len, tbl_code} = {6'd5, 21'b10010};
                    24'h000002: {tbl_len, tbl_code} = {6'd5, 21'b10011};
                    24'h000010: {tbl_len, tbl_code} = {6'd5, 21'b10100};
                    24'h000100: {tbl_len, tbl_code} = {6'd5, 21'b10101};
                    24'h001001: {tbl_len, tbl_code} = {6'd9, 21'b111101101};
                    24'h001002: {tbl_len, tbl_code} = {6'd9, 21'b111101110};
                    24'h000011: {tbl_len, tbl_code} = {6'd9, 21'b111101001};
                    24'h000012: {tbl_len, tbl_code} = {6'd9, 21'b111101010};
                    24'h000101: {tbl_len, tbl_code} = {6'd9, 21'b111101011};
                    24'h000102: {tbl_len, tbl_code} = {6'd9, 21'b111101100};
                    24'h00000F: {tbl_len, tbl_code} = {6'd12, 21'b111111111000};
                    24'h00100F: {tbl_len, tbl_code} = {6'd15, 21'b111111111111001};
                    24'h00010F: {tbl_len, tbl_code} = {6'd15, 21'b111111111111000};
                    default:    tbl_hit = 1'b0;
                endcase
            end
            default: tbl_hit = 1'b0;   // counts 0 and 7 up
        endcase
    end

    // stray upper digits or bad count kill the hit
    assign hit = tbl_hit & in_range_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            match_o  <= 1'b0;
            length_o <= '0;
            code_o   <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin   // hold last result otherwise
                match_o  <= hit;
                length_o <= hit ? tbl_len : '0;
                code_o   <= hit ? tbl_code : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/codebook_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module codebook_encoder (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         valid_i,
    input  wire codebook_pkg::ap_cnt_t  ap_cnt_i,
    input  wire codebook_pkg::ap_data_t ap_data_i,

    output wire                          valid_o,
    output wire                          encode_match_o,
    output wire codebook_pkg::code_len_t encode_length_o,
    output wire codebook_pkg::code_t     encode_data_o
);

    wire                        dec_valid;
    wire codebook_pkg::ap_cnt_t dec_cnt;
    wire codebook_pkg::ap_key_t dec_key;
    wire                        dec_in_range;

    // stage 1, range check and key
    ap_decode u_ap_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .ap_cnt_i   (ap_cnt_i),
        .ap_data_i  (ap_data_i),
        .valid_o    (dec_valid),
        .cnt_o      (dec_cnt),
        .key_o      (dec_key),
        .in_range_o (dec_in_range)
    );

    code_lookup u_code_lookup (   // stage 2, table and result regs
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (dec_valid),
        .cnt_i      (dec_cnt),
        .key_i      (dec_key),
        .in_range_i (dec_in_range),
        .valid_o    (valid_o),
        .match_o    (encode_match_o),
        .length_o   (encode_length_o),
        .code_o     (encode_data_o)
    );

endmodule

`default_nettype wire

/* hdl/codebook_pkg.sv */
`default_nettype none

package codebook_pkg;

    // input pattern
    localparam int AP_CNT_W     = 6;
    localparam int AP_DATA_W    = 64;
    localparam int SYM_W        = 4;   // one digit of the pattern

    // counts above this always miss
    localparam int KEPT_CNT_MAX = 6;
    localparam int KEY_W        = KEPT_CNT_MAX * SYM_W;

    // result
    localparam int CODE_W       = 21;
    localparam int LEN_W        = 6;

    typedef logic [AP_CNT_W-1:0]  ap_cnt_t;
    typedef logic [AP_DATA_W-1:0] ap_data_t;
    typedef logic [KEY_W-1:0]     ap_key_t;
    typedef logic [CODE_W-1:0]    code_t;   // right-aligned
    typedef logic [LEN_W-1:0]     code_len_t;

    // digits that occur in codebook patterns
    typedef enum logic [SYM_W-1:0] {
        SYM_ZERO = 4'h0,
        SYM_ONE  = 4'h1,
        SYM_TWO  = 4'h2,
        SYM_ESC  = 4'hF    // escape digit
    } ap_sym_e;

endpackage

`default_nettype wire

/* test/codebook_cases.txt */
# count(dec) data(hex) match(0/1) length(dec) code(hex)
# kept codebook entries, counts 1 to 6
1 1 1 4 4
1 2 1 4 5
1 F 1 10 3E8
2 1 1 4 6
2 F 1 11 7F8
3 21 1 8 E8
3 22 1 9 1DE
3 F 1 11 7F9
3 2F 1 15 7FF0
4 11 1 8 E9
4 12 1 8 EA
4 21 1 8 EB
4 201 1 8 EC
4 22 1 9 1DF
4 202 1 9 1E0
4 F 1 11 7FA
4 1F 1 15 7FF1
4 2F 1 15 7FF2
4 20F 1 15 7FF3
5 200 1 5 10
5 2000 1 5 11
5 2 1 5 E
5 20 1 5 F
5 101 1 8 EE
5 11 1 8 ED
5 102 1 9 1E4
5 201 1 9 1E5
5 202 1 9 1E6
5 2001 1 9 1E7
5 2002 1 9 1E8
5 12 1 9 1E1
5 21 1 9 1E2
5 22 1 9 1E3
5 F 1 11 7FB
5 10F 1 15 7FF5
5 200F 1 15 7FF6
5 1F 1 15 7FF4
5 2F 1 16 FFF4
6 1000 1 5 16
6 1 1 5 12
6 2 1 5 13
6 10 1 5 14
6 100 1 5 15
6 1001 1 9 1ED
6 1002 1 9 1EE
6 11 1 9 1E9
6 12 1 9 1EA
6 101 1 9 1EB
6 102 1 9 1EC
6 F 1 12 FF8
6 100F 1 15 7FF9
6 10F 1 15 7FF8
# counts outside 1 to 6
0 0 0 0 0
0 1 0 0 0
7 1 0 0 0
7 1000 0 0 0
8 2 0 0 0
9 F 0 0 0
10 21 0 0 0
11 F 0 0 0
12 1001 0 0 0
63 1 0 0 0
# nonzero digits above the count
1 11 0 0 0
2 101 0 0 0
3 1021 0 0 0
4 1000012 0 0 0
5 1000002 0 0 0
6 1000001 0 0 0
6 8000000000000001 0 0 0
5 1 0 0 0

/* test/codebook_encoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module codebook_encoder_tb;

    localparam int LATENCY = 2;     // valid_i sample edge to valid_o sample edge
    localparam int N_RAND  = 120;

    typedef struct packed {
        codebook_pkg::ap_cnt_t   cnt;
        codebook_pkg::ap_data_t  data;
        logic                    match;
        codebook_pkg::code_len_t len;
        codebook_pkg::code_t     code;
        logic [31:0]             issue;   // cycle count when driven
    } case_t;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    valid_i;
    codebook_pkg::ap_cnt_t   ap_cnt_i;
    codebook_pkg::ap_data_t  ap_data_i;
    wire                     valid_o;
    wire                     encode_match_o;
    codebook_pkg::code_len_t encode_length_o;
    codebook_pkg::code_t     encode_data_o;

    case_t  file_q[$];
    case_t  exp_q[$];
    integer seed = 32'hd790a804;
    int     cyc = 0;
    int     cyc_limit = 1000;
    int     sent = 0;
    int     pulses = 0;

    codebook_encoder u_codebook_encoder (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .ap_cnt_i        (ap_cnt_i),
        .ap_data_i       (ap_data_i),
        .valid_o         (valid_o),
        .encode_match_o  (encode_match_o),
        .encode_length_o (encode_length_o),
        .encode_data_o   (encode_data_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_match(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR @ %0t: %s match got %b expected %b", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_length(input codebook_pkg::code_len_t got,
                                input codebook_pkg::code_len_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @ %0t: %s length got %0d expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_code(input codebook_pkg::code_t got,
                              input codebook_pkg::code_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @ %0t: %s code got %0h expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR @ %0t: %s valid_o at cycle %0d expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic is_symbol(input logic [3:0] d);
        return d == codebook_pkg::SYM_ZERO || d == codebook_pkg::SYM_ONE ||
               d == codebook_pkg::SYM_TWO || d == codebook_pkg::SYM_ESC;
    endfunction

    // random counted digits with one outside the alphabet
    task automatic make_miss(output case_t c);
        codebook_pkg::ap_data_t data;
        int         cnt;
        int         pos;
        int         j;
        logic [3:0] dig;
        data = '0;
        cnt = 1 + ($unsigned($random(seed)) % codebook_pkg::KEPT_CNT_MAX);
        for (j = 0; j < cnt; j++) begin
            data[j*codebook_pkg::SYM_W +: codebook_pkg::SYM_W] = 4'($random(seed));
        end
        pos = $unsigned($random(seed)) % cnt;
        dig = 4'($random(seed));
        while (is_symbol(dig)) begin
            dig = 4'($random(seed));
        end
        data[pos*codebook_pkg::SYM_W +: codebook_pkg::SYM_W] = dig;
        c = '0;
        c.cnt = codebook_pkg::ap_cnt_t'(cnt);
        c.data = data;
    endtask

    task automatic insert_gap();
        if (($random(seed) & 3) == 0) begin
            @(negedge clk_i);
            valid_i   = 1'b0;
            ap_data_i = {$random(seed), $random(seed)};   // ignored while idle
        end
    endtask

    task automatic send_case(input case_t c);
        @(negedge clk_i);
        valid_i   = 1'b1;
        ap_cnt_i  = c.cnt;
        ap_data_i = c.data;
        c.issue   = cyc;
        exp_q.push_back(c);
        sent++;
    endtask

    always @(posedge clk_i) begin : monitor
        case_t e;
        string what;
        cyc = cyc + 1;
        if (cyc > cyc_limit) begin
            stop_with_failure($sformatf("timeout at cycle %0d with %0d results outstanding",
                                        cyc, exp_q.size()));
        end else if (cyc >= 2 && cyc <= 4) begin
            check_match(valid_o, 1'b0, "reset valid_o");
            check_match(encode_match_o, 1'b0, "reset");
            check_length(encode_length_o, '0, "reset");
            check_code(encode_data_o, '0, "reset");
        end else if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("valid_o pulsed with no pattern outstanding");
            end else begin
                e = exp_q.pop_front();
                what = $sformatf("cnt %0d data %0h", e.cnt, e.data);
                check_latency(cyc, e.issue + 1 + LATENCY, what);
                check_match(encode_match_o, e.match, what);
                check_length(encode_length_o, e.len, what);
                check_code(encode_data_o, e.code, what);
                pulses++;
            end
        end
    end

    initial begin : stimulus
        integer           fd;
        logic [8*128-1:0] line;
        integer           n;
        integer           c;
        integer           m;
        integer           l;
        logic [63:0]      d;
        logic [31:0]      k;
        case_t            tc;
        int               i;

        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        ap_cnt_i  = '0;
        ap_data_i = '0;

        fd = $fopen("test/codebook_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open test/codebook_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%d %h %d %d %h", c, d, m, l, k);
                    if (n == 5) begin   // comment lines give 0
                        tc = '0;
                        tc.cnt   = codebook_pkg::ap_cnt_t'(c);
                        tc.data  = d;
                        tc.match = m[0];
                        tc.len   = codebook_pkg::code_len_t'(l);
                        tc.code  = codebook_pkg::code_t'(k);
                        file_q.push_back(tc);
                    end
                end
            end
            $fclose(fd);
        end
        cyc_limit = 4 * (file_q.size() + N_RAND) + 50;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        for (i = 0; i < file_q.size(); i++) begin
            insert_gap();
            send_case(file_q[i]);
        end
        for (i = 0; i < N_RAND; i++) begin
            make_miss(tc);
            insert_gap();
            send_case(tc);
        end
        @(negedge clk_i);
        valid_i = 1'b0;

        repeat (LATENCY + 4) @(negedge clk_i);   // last result and any stray pulses

        if (file_q.size() == 0 || exp_q.size() != 0 || pulses != sent) begin
            stop_with_failure($sformatf("%0d cases read, %0d sent, %0d results, %0d left",
                                        file_q.size(), sent, pulses, exp_q.size()));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
